/* hdl/wb_bus_consts.svh */
// Wishbone shared-bus constants giving the bus sizes and the slave address map
`ifndef WB_BUS_CONSTS_SVH
`define WB_BUS_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus topology
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WB_NUM_MASTERS 2
`define WB_NUM_SLAVES  3

// Data path widths, one select bit per byte lane
`define WB_ADR_W  32
`define WB_DATA_W 32
`define WB_SEL_W  (`WB_DATA_W / 8)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slave memories and address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WB_SLAVE_WORDS  64
`define WB_WINDOW_BYTES (4 * `WB_SLAVE_WORDS)
`define WB_BASE0        32'h0000_0000
`define WB_BASE1        32'h0000_1000
`define WB_BASE2        32'h0000_2000

`endif

/* hdl/wb_bus_pkg.sv */
// Wishbone bus package with the opcode, request and response types of the shared bus
`default_nettype none

`include "wb_bus_consts.svh"

package wb_bus_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Takes the place of the WE line
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } wb_op_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Request and response
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Master to slave direction, dat carries write data
   typedef struct packed
   {
      logic                  cyc;
      logic                  stb;
      wb_op_e                op;
      logic [`WB_ADR_W-1:0]  adr;
      logic [`WB_SEL_W-1:0]  sel;
      logic [`WB_DATA_W-1:0] dat;
   } wb_req_t;

   // Slave to master direction, dat carries read data
   // Stall is combinational while ack and err are registered
   typedef struct packed
   {
      logic                  ack;
      logic                  err;
      logic                  stall;
      logic [`WB_DATA_W-1:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/wb_priority_arbiter.sv */
// Wishbone priority arbiter that locks the shared bus to one master per bus cycle
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_priority_arbiter
(
   input  logic                                      wbm_i,
   input  logic                                      arst_n_i,
   input  wb_bus_pkg::wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   output wb_bus_pkg::wb_req_t                       bus_req_o,
   output logic [`WB_NUM_MASTERS-1:0]                owner_o,
   output logic [`WB_NUM_MASTERS-1:0]                stall_o
);

   logic [`WB_NUM_MASTERS-1:0] cyc;
   logic [`WB_NUM_MASTERS-1:0] owner_q;
   logic [`WB_NUM_MASTERS-1:0] grant;
   logic                       locked;

   always_comb
   begin
      for (int i = 0; i < `WB_NUM_MASTERS; i++)
      begin
         cyc[i] = m_req_i[i].cyc;
      end
   end

   // The previous owner keeps the bus for as long as it holds cyc
   assign locked = |(owner_q & cyc);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Grant
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // On a free bus the lowest index wins, so scan downward and let it overwrite
   always_comb
   begin
      grant = '0;
      if (locked)
      begin
         grant = owner_q;
      end
      else
      begin
         for (int i = `WB_NUM_MASTERS - 1; i >= 0; i--)
         begin
            if (cyc[i])
            begin
               grant    = '0;
               grant[i] = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge wbm_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         owner_q <= '0;
      end
      else
      begin
         owner_q <= grant;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus mux and stall
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      bus_req_o = '0;
      for (int i = 0; i < `WB_NUM_MASTERS; i++)
      begin
         if (grant[i])
         begin
            bus_req_o = m_req_i[i];
         end
      end
   end

   // Slaves never stall, so only a master without the bus is held off
   assign stall_o = cyc & ~grant;
   assign owner_o = grant;

   owner_onehot0: assert property (@(posedge wbm_i) disable iff (!arst_n_i)
      $onehot0(owner_o));

endmodule

`default_nettype wire

/* hdl/wb_addr_decoder.sv */
// Wishbone address decoder that steers the shared strobe to one slave window
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_addr_decoder
(
   input  wb_bus_pkg::wb_req_t                      bus_req_i,
   output wb_bus_pkg::wb_req_t [`WB_NUM_SLAVES-1:0] s_req_o,
   output logic [`WB_NUM_SLAVES-1:0]                s_sel_o,
   output logic                                     miss_o
);

   localparam logic [`WB_ADR_W-1:0] BASE [`WB_NUM_SLAVES] =
      '{`WB_BASE0, `WB_BASE1, `WB_BASE2};

   logic [`WB_NUM_SLAVES-1:0] hit;
   logic                      strobe;

   assign strobe = bus_req_i.cyc & bus_req_i.stb;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Window compare
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      for (int i = 0; i < `WB_NUM_SLAVES; i++)
      begin
         hit[i] = (bus_req_i.adr >= BASE[i]) &&
                  (bus_req_i.adr < BASE[i] + `WB_WINDOW_BYTES);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Slave requests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Every slave sees cyc but only the hit slave gets stb and the payload
   always_comb
   begin
      for (int i = 0; i < `WB_NUM_SLAVES; i++)
      begin
         s_req_o[i]     = '0;
         s_req_o[i].cyc = bus_req_i.cyc;
         s_req_o[i].op  = bus_req_i.op;
         if (hit[i])
         begin
            s_req_o[i].stb = strobe;
            s_req_o[i].adr = bus_req_i.adr;
            s_req_o[i].sel = bus_req_i.sel;
            s_req_o[i].dat = bus_req_i.dat;
         end
      end
   end

   assign s_sel_o = hit;

   // A strobe that lands in no window is answered with err by the router
   assign miss_o = strobe & ~(|hit);

   // Overlapping windows in the address map would break one-hot routing
   sel_onehot0: assert final ($onehot0(s_sel_o));

endmodule

`default_nettype wire

/* hdl/wb_ram_slave.sv */
// Wishbone RAM slave with byte selects and a fixed one-cycle ack
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_ram_slave
#(
   parameter int DEPTH = `WB_SLAVE_WORDS
)
(
   input  logic                wbm_i,
   input  logic                arst_n_i,
   input  wb_bus_pkg::wb_req_t req_i,
   output wb_bus_pkg::wb_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(DEPTH);

   logic [`WB_DATA_W-1:0] mem [DEPTH];
   logic [`WB_DATA_W-1:0] rd_dat_q;
   logic [IDX_W-1:0]      idx;
   logic                  strobe;
   logic                  ack_q;

   assign strobe = req_i.cyc & req_i.stb;

   // Byte address down to a word index inside the window
   assign idx = req_i.adr[IDX_W+1:2];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge wbm_i)
   begin
      if (strobe)
      begin
         if (req_i.op == wb_bus_pkg::OP_WRITE)
         begin
            for (int b = 0; b < `WB_SEL_W; b++)
            begin
               if (req_i.sel[b])
               begin
                  mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         rd_dat_q <= mem[idx];
      end
   end

   // Every accepted strobe is acked on the next clock
   always_ff @(posedge wbm_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= strobe;
      end
   end

   always_comb
   begin
      rsp_o       = '0;
      rsp_o.ack   = ack_q;
      rsp_o.dat   = rd_dat_q;
   end

   no_stray_ack: assert property (@(posedge wbm_i) disable iff (!arst_n_i)
      !strobe |=> !rsp_o.ack);

endmodule

`default_nettype wire

/* hdl/wb_response_router.sv */
// Wishbone response router that returns ack, err and read data to the requesting master
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_response_router
(
   input  logic                                      wbm_i,
   input  logic                                      arst_n_i,
   input  logic [`WB_NUM_MASTERS-1:0]                owner_i,
   input  logic [`WB_NUM_SLAVES-1:0]                 s_sel_i,
   input  logic                                      miss_i,
   input  logic                                      accept_i,
   input  wb_bus_pkg::wb_rsp_t [`WB_NUM_SLAVES-1:0]  s_rsp_i,
   output wb_bus_pkg::wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_o,
   input  logic [`WB_NUM_MASTERS-1:0]                stall_i
);

   logic [`WB_NUM_MASTERS-1:0] owner_q;
   logic [`WB_NUM_SLAVES-1:0]  sel_q;
   logic                       miss_q;
   logic                       ack_any;
   logic                       err_any;
   logic [`WB_DATA_W-1:0]      rd_dat;
   logic [`WB_NUM_MASTERS-1:0] delivered;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Capture at acceptance
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Cleared on idle cycles so a miss raises err for one cycle only
   always_ff @(posedge wbm_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         owner_q <= '0;
         sel_q   <= '0;
         miss_q  <= 1'b0;
      end
      else
      begin
         owner_q <= accept_i ? owner_i : '0;
         sel_q   <= accept_i ? s_sel_i : '0;
         miss_q  <= accept_i & miss_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Response merge and routing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      ack_any = 1'b0;
      err_any = miss_q;
      rd_dat  = '0;
      for (int s = 0; s < `WB_NUM_SLAVES; s++)
      begin
         ack_any = ack_any | s_rsp_i[s].ack;
         err_any = err_any | s_rsp_i[s].err;
         if (sel_q[s])
         begin
            rd_dat = s_rsp_i[s].dat;
         end
      end
   end

   always_comb
   begin
      for (int m = 0; m < `WB_NUM_MASTERS; m++)
      begin
         m_rsp_o[m].ack   = owner_q[m] & ack_any;
         m_rsp_o[m].err   = owner_q[m] & err_any;
         m_rsp_o[m].stall = stall_i[m];
         m_rsp_o[m].dat   = owner_q[m] ? rd_dat : '0;
         delivered[m]     = m_rsp_o[m].ack | m_rsp_o[m].err;
      end
   end

   rsp_one_master: assert property (@(posedge wbm_i) disable iff (!arst_n_i)
      (ack_any || err_any) |-> $onehot(delivered));

   // A slave answer without a bus acceptance one cycle earlier is lost
   rsp_after_accept: assert property (@(posedge wbm_i) disable iff (!arst_n_i)
      (ack_any || err_any) |-> $past(accept_i));

endmodule

`default_nettype wire

/* hdl/wb_sharedbus_top.sv */
// Wishbone shared-bus subsystem joining two masters to three RAM slaves
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_sharedbus_top
(
   input  logic                                      wbm_i,
   input  logic                                      arst_n_i,
   input  wb_bus_pkg::wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   output wb_bus_pkg::wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_o
);

   wb_bus_pkg::wb_req_t                      bus_req;
   wb_bus_pkg::wb_req_t [`WB_NUM_SLAVES-1:0] s_req;
   wb_bus_pkg::wb_rsp_t [`WB_NUM_SLAVES-1:0] s_rsp;
   logic [`WB_NUM_MASTERS-1:0]               owner;
   logic [`WB_NUM_MASTERS-1:0]               stall;
   logic [`WB_NUM_SLAVES-1:0]                s_sel;
   logic                                     miss;
   logic                                     accept;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Request path
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   wb_priority_arbiter u_arbiter
   (
      .wbm_i     (wbm_i),
      .arst_n_i  (arst_n_i),
      .m_req_i   (m_req_i),
      .bus_req_o (bus_req),
      .owner_o   (owner),
      .stall_o   (stall)
   );

   // The owner never sees stall, so a strobe on the shared bus is taken
   assign accept = bus_req.cyc & bus_req.stb;

   wb_addr_decoder u_decoder
   (
      .bus_req_i (bus_req),
      .s_req_o   (s_req),
      .s_sel_o   (s_sel),
      .miss_o    (miss)
   );

   for (genvar i = 0; i < `WB_NUM_SLAVES; i++)
   begin : g_slave
      wb_ram_slave #(.DEPTH(`WB_SLAVE_WORDS)) u_ram
      (
         .wbm_i    (wbm_i),
         .arst_n_i (arst_n_i),
         .req_i    (s_req[i]),
         .rsp_o    (s_rsp[i])
      );
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Response path
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   wb_response_router u_router
   (
      .wbm_i    (wbm_i),
      .arst_n_i (arst_n_i),
      .owner_i  (owner),
      .s_sel_i  (s_sel),
      .miss_i   (miss),
      .accept_i (accept),
      .s_rsp_i  (s_rsp),
      .m_rsp_o  (m_rsp_o),
      .stall_i  (stall)
   );

endmodule

`default_nettype wire

/* verif/wb_sharedbus_checker.sv */
// Wishbone shared-bus checker that models arbitration and memory and compares DUT responses
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_sharedbus_checker
(
   input  logic                                      wbm_i,
   input  logic                                      arst_n_i,
   input  wb_bus_pkg::wb_req_t [`WB_NUM_MASTERS-1:0] m_req_i,
   input  wb_bus_pkg::wb_rsp_t [`WB_NUM_MASTERS-1:0] m_rsp_i,
   output logic [`WB_NUM_MASTERS-1:0]                pending_o,
   output int                                        err_count_o
);

   // One accepted request waiting for its response
   typedef struct packed
   {
      logic [31:0]           cycle;
      logic                  miss;
      logic                  write;
      logic [`WB_DATA_W-1:0] exp_dat;
   } pend_t;

   logic [7:0]                 model_mem [`WB_NUM_SLAVES][`WB_WINDOW_BYTES];
   pend_t                      pend_q [`WB_NUM_MASTERS][$];
   logic [`WB_NUM_MASTERS-1:0] own_q;
   logic [31:0]                cycle;

   initial
   begin
      err_count_o = 0;
   end

   function automatic logic [`WB_ADR_W-1:0] base_of(input int s);
      case (s)
         0:       base_of = `WB_BASE0;
         1:       base_of = `WB_BASE1;
         default: base_of = `WB_BASE2;
      endcase
   endfunction

   // Returns the slave whose window holds the address, or -1 on a miss
   function automatic int window_of(input logic [`WB_ADR_W-1:0] adr);
      window_of = -1;
      for (int s = 0; s < `WB_NUM_SLAVES; s++)
      begin
         if ((adr - base_of(s)) < `WB_WINDOW_BYTES)
         begin
            window_of = s;
         end
      end
   endfunction

   task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("** Error: %s expected 0x%h got 0x%h (cycle %0d)", name, exp, got, cycle);
      err_count_o++;
   endtask

   task automatic report_text(input string text);
      $display("Checker: %s (cycle %0d)", text, cycle);
      err_count_o++;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Per-cycle compare
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(posedge wbm_i or negedge arst_n_i)
   begin
      logic [`WB_NUM_MASTERS-1:0] cyc;
      logic [`WB_NUM_MASTERS-1:0] grant;
      int                         taken;
      int                         s;
      int                         off;
      pend_t                      e;
      if (!arst_n_i)
      begin
         own_q     = '0;
         cycle     = 0;
         pending_o = '0;
         for (int m = 0; m < `WB_NUM_MASTERS; m++)
         begin
            pend_q[m].delete();
         end
      end
      else
      begin
         cycle = cycle + 1;
         // Responses belong to the request accepted on the previous edge
         for (int m = 0; m < `WB_NUM_MASTERS; m++)
         begin
            if (pend_q[m].size() != 0 && pend_q[m][0].cycle + 1 == cycle)
            begin
               e = pend_q[m].pop_front();
               if (m_rsp_i[m].ack !== !e.miss)
                  report_value($sformatf("m%0d_rsp.ack", m), !e.miss, m_rsp_i[m].ack);
               if (m_rsp_i[m].err !== e.miss)
                  report_value($sformatf("m%0d_rsp.err", m), e.miss, m_rsp_i[m].err);
               if (!e.miss && !e.write && m_rsp_i[m].dat !== e.exp_dat)
                  report_value($sformatf("m%0d_rsp.dat", m), e.exp_dat, m_rsp_i[m].dat);
            end
            else if (m_rsp_i[m].ack === 1'b1 || m_rsp_i[m].err === 1'b1)
            begin
               report_text($sformatf("master %0d got a response without a request", m));
            end
         end

         // Owner holds the bus while its cyc stays high and master 0 wins a free bus
         for (int m = 0; m < `WB_NUM_MASTERS; m++)
         begin
            cyc[m] = m_req_i[m].cyc;
         end
         grant = '0;
         if (|(own_q & cyc))
            grant = own_q;
         else
            for (int m = 0; m < `WB_NUM_MASTERS; m++)
               if (cyc[m] && grant == '0)
                  grant[m] = 1'b1;

         taken = 0;
         for (int m = 0; m < `WB_NUM_MASTERS; m++)
         begin
            if (m_rsp_i[m].stall !== (cyc[m] & ~grant[m]))
               report_value($sformatf("m%0d_rsp.stall", m), cyc[m] & ~grant[m], m_rsp_i[m].stall);
            if (m_req_i[m].cyc && m_req_i[m].stb && m_rsp_i[m].stall === 1'b0)
            begin
               taken++;
               s         = window_of(m_req_i[m].adr);
               e.cycle   = cycle;
               e.miss    = (s < 0);
               e.write   = (m_req_i[m].op == wb_bus_pkg::OP_WRITE);
               e.exp_dat = '0;
               if (s >= 0)
               begin
                  off = ((m_req_i[m].adr - base_of(s)) >> 2) << 2;
                  for (int b = 0; b < `WB_SEL_W; b++)
                  begin
                     e.exp_dat[8*b +: 8] = model_mem[s][off+b];
                     if (e.write && m_req_i[m].sel[b])
                        model_mem[s][off+b] = m_req_i[m].dat[8*b +: 8];
                  end
               end
               pend_q[m].push_back(e);
            end
         end
         if (taken > 1)
            report_text("more than one master was accepted in the same cycle");

         own_q = grant;
         for (int m = 0; m < `WB_NUM_MASTERS; m++)
         begin
            pending_o[m] = (pend_q[m].size() != 0);
         end
      end
   end

endmodule

`default_nettype wire

/* verif/wb_sharedbus_tb.sv */
// Wishbone shared-bus testbench driving two masters with directed and random traffic
`timescale 1ns/100ps
`default_nettype none

`include "wb_bus_consts.svh"

module wb_sharedbus_tb;

   localparam int WAIT_LIMIT = 200;
   localparam int NM         = `WB_NUM_MASTERS;

   logic                         wbm;
   logic                         arst_n;
   wb_bus_pkg::wb_req_t [NM-1:0] m_req;
   wb_bus_pkg::wb_rsp_t [NM-1:0] m_rsp;
   logic [NM-1:0]                pending;
   int                           chk_errors;
   int                           tb_errors;
   int                           tests_run;
   int                           tests_failed;
   int                           errors_at_start;
   int                           accept_count [NM];
   logic [31:0]                  lfsr_state [NM];

   wb_sharedbus_top DUT
   (
      .wbm_i    (wbm),
      .arst_n_i (arst_n),
      .m_req_i  (m_req),
      .m_rsp_o  (m_rsp)
   );

   wb_sharedbus_checker u_checker
   (
      .wbm_i       (wbm),
      .arst_n_i    (arst_n),
      .m_req_i     (m_req),
      .m_rsp_i     (m_rsp),
      .pending_o   (pending),
      .err_count_o (chk_errors)
   );

   always #5 wbm = ~wbm;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Random values
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Fibonacci LFSR with taps 32, 22, 2, 1, one stream per master
   function automatic logic [31:0] rand_bits(input int m, input int n);
      logic [31:0] s;
      logic [31:0] r;
      logic        fb;
      s = lfsr_state[m];
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = s[31] ^ s[21] ^ s[1] ^ s[0];
         s  = {s[30:0], fb};
         r  = {r[30:0], fb};
      end
      lfsr_state[m] = s;
      return r;
   endfunction

   function automatic logic [31:0] base_addr(input int s);
      case (s)
         0:       base_addr = `WB_BASE0;
         1:       base_addr = `WB_BASE1;
         default: base_addr = `WB_BASE2;
      endcase
   endfunction

   function automatic logic [31:0] rand_hit_addr(input int m);
      logic [31:0] slot;
      slot = rand_bits(m, 8) % `WB_NUM_SLAVES;
      return base_addr(slot) + (rand_bits(m, 6) << 2);
   endfunction

   // About one address in sixteen falls past the last window
   function automatic logic [31:0] rand_addr(input int m);
      if (rand_bits(m, 4) == 0)
         return 32'h0000_3000 + (rand_bits(m, 6) << 2);
      return rand_hit_addr(m);
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Master tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic transfer(input int m, input wb_bus_pkg::wb_op_e op, input logic [31:0] adr,
                           input logic [3:0] sel, input logic [31:0] dat, input bit lone);
      int waited;
      bit taken;
      @(negedge wbm);
      m_req[m].cyc = 1'b1;
      m_req[m].stb = 1'b1;
      m_req[m].op  = op;
      m_req[m].adr = adr;
      m_req[m].sel = sel;
      m_req[m].dat = dat;
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < WAIT_LIMIT)
      begin
         @(posedge wbm);
         taken = (m_rsp[m].stall == 1'b0);
         waited++;
      end
      if (!taken)
      begin
         $display("Master %0d request to 0x%h was never accepted", m, adr);
         tb_errors++;
      end
      else
      begin
         accept_count[m]++;
         if (lone && m_req[1-m].cyc)
         begin
            $display("Master %0d was accepted while master %0d held cyc", m, 1 - m);
            tb_errors++;
         end
      end
   endtask

   // Keeps cyc until the last response has come back
   task automatic finish_cycle(input int m);
      int waited;
      @(negedge wbm);
      m_req[m].stb = 1'b0;
      waited = 0;
      while (pending[m] && waited < WAIT_LIMIT)
      begin
         @(negedge wbm);
         waited++;
      end
      if (pending[m])
      begin
         $display("Master %0d response never arrived", m);
         tb_errors++;
      end
      m_req[m].cyc = 1'b0;
   endtask

   task automatic random_burst(input int m, input int n, input bit lone);
      wb_bus_pkg::wb_op_e op;
      logic [31:0]        adr;
      logic [3:0]         sel;
      logic [31:0]        dat;
      for (int i = 0; i < n; i++)
      begin
         op  = rand_bits(m, 1) ? wb_bus_pkg::OP_WRITE : wb_bus_pkg::OP_READ;
         adr = rand_addr(m);
         sel = rand_bits(m, 4);
         dat = rand_bits(m, 32);
         transfer(m, op, adr, sel, dat, lone && i == 0);
      end
      finish_cycle(m);
   endtask

   // Waits until the other master has been accepted, then requests the bus
   task automatic burst_after_other(input int m, input int n);
      int waited;
      int start;
      start  = accept_count[1-m];
      waited = 0;
      while (accept_count[1-m] == start && waited < WAIT_LIMIT)
      begin
         @(negedge wbm);
         waited++;
      end
      if (accept_count[1-m] == start)
      begin
         $display("Master %0d never got the bus", 1 - m);
         tb_errors++;
      end
      random_burst(m, n, 1'b1);
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
         @(negedge wbm);
   endtask

   task automatic close_test(input int num, input string name);
      int now;
      now = chk_errors + tb_errors;
      tests_run++;
      if (now != errors_at_start)
      begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d new errors", num, name, now - errors_at_start);
      end
      else
         $display("Test %0d %s: passed", num, name);
      errors_at_start = now;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      logic [31:0] adr;
      logic [31:0] miss_adr [4];
      wbm             = 1'b0;
      arst_n          = 1'b0;
      m_req           = '0;
      tb_errors       = 0;
      tests_run       = 0;
      tests_failed    = 0;
      errors_at_start = 0;
      accept_count    = '{0, 0};
      lfsr_state[0]   = 32'hca21;
      lfsr_state[1]   = rand_bits(0, 32) | 32'h1;
      repeat (3) @(negedge wbm);
      arst_n = 1'b1;

      // Fill every word first so each later read has known bytes
      for (int s = 0; s < `WB_NUM_SLAVES; s++)
         for (int w = 0; w < `WB_SLAVE_WORDS; w++)
         begin
            adr = base_addr(s) + w * 4;
            transfer(0, wb_bus_pkg::OP_WRITE, adr, 4'hf, adr * 32'h9e37_79b9, 1'b0);
         end
      for (int i = 0; i < 48; i++)
      begin
         adr = rand_hit_addr(0);
         transfer(0, wb_bus_pkg::OP_WRITE, adr, rand_bits(0, 4), rand_bits(0, 32), 1'b0);
         transfer(0, wb_bus_pkg::OP_READ, adr, 4'hf, '0, 1'b0);
      end
      finish_cycle(0);
      close_test(1, "write_read");

      miss_adr = '{`WB_BASE0 + `WB_WINDOW_BYTES, `WB_BASE1 + `WB_WINDOW_BYTES,
                   `WB_BASE2 + `WB_WINDOW_BYTES, 32'hffff_fffc};
      for (int i = 0; i < 4; i++)
      begin
         transfer(0, wb_bus_pkg::OP_WRITE, miss_adr[i], 4'hf, rand_bits(0, 32), 1'b0);
         transfer(0, wb_bus_pkg::OP_READ, miss_adr[i], 4'hf, '0, 1'b0);
      end
      // Word 0 of each slave would be hit if a miss aliased into a window
      for (int s = 0; s < `WB_NUM_SLAVES; s++)
         transfer(0, wb_bus_pkg::OP_READ, base_addr(s), 4'hf, '0, 1'b0);
      finish_cycle(0);
      close_test(2, "decode_error");

      fork
         random_burst(0, 5, 1'b0);
         random_burst(1, 3, 1'b1);
      join
      close_test(3, "arbitration");

      fork
         random_burst(1, 6, 1'b0);
         burst_after_other(0, 3);
      join
      close_test(4, "bus_lock");

      for (int r = 0; r < 12; r++)
      begin
         fork
            begin
               idle_cycles(rand_bits(0, 2));
               random_burst(0, 1 + rand_bits(0, 3), 1'b0);
            end
            begin
               idle_cycles(rand_bits(1, 2));
               random_burst(1, 1 + rand_bits(1, 3), 1'b0);
            end
         join
      end
      close_test(5, "routing");

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
               chk_errors + tb_errors);
      if (chk_errors + tb_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/wb_bus_pkg.sv
hdl/wb_priority_arbiter.sv
hdl/wb_addr_decoder.sv
hdl/wb_ram_slave.sv
hdl/wb_response_router.sv
hdl/wb_sharedbus_top.sv
verif/wb_sharedbus_checker.sv
verif/wb_sharedbus_tb.sv

/* Bender.yml */
package:
  name: wb_sharedbus

sources:
  # RTL, the package first
  - include_dirs:
      - hdl
    files:
      - hdl/wb_bus_pkg.sv
      - hdl/wb_priority_arbiter.sv
      - hdl/wb_addr_decoder.sv
      - hdl/wb_ram_slave.sv
      - hdl/wb_response_router.sv
      - hdl/wb_sharedbus_top.sv

  # Testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/wb_sharedbus_checker.sv
      - verif/wb_sharedbus_tb.sv
